/* files.f */
+incdir+sim
design/regex_pkg.sv
design/parity_bram.sv
design/regex_coprocessor.sv
design/host_ctrl.sv
design/regex_top.sv
sim/tb_regex_top.sv

/* Bender.yml */
package:
  name: regex_coprocessor

sources:
  - files:
      - design/regex_pkg.sv
      - design/parity_bram.sv
      - design/regex_coprocessor.sv
      - design/host_ctrl.sv
      - design/regex_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_regex_top.sv

/* sim/regex_model.svh */
`ifndef REGEX_MODEL_SVH
`define REGEX_MODEL_SVH

// works on the shadow array of memory words in the including module

// opcode in the upper byte, operand in the lower byte
function automatic logic [15:0] instr_word(input logic [7:0] op, input logic [7:0] operand);
    return {op, operand};
endfunction

// one character per word, low byte only
function automatic logic [15:0] char_word(input logic [7:0] c);
    return {8'h00, c};
endfunction

// anchored match, program at word 0, text at start
function automatic bit model_verdict(input logic [regex_pkg::mem_addr_width-1:0] start);
    logic [regex_pkg::mem_addr_width-1:0] pc;
    logic [regex_pkg::mem_addr_width-1:0] cc;
    logic [7:0]                           op;
    logic [7:0]                           operand;
    logic [7:0]                           c;
    pc = '0;
    cc = start;
    for (int step = 0; step < regex_pkg::mem_depth; step++)
    begin
        op      = shadow[pc][15:8];
        operand = shadow[pc][7:0];
        c       = shadow[cc][7:0];
        if (op == regex_pkg::op_accept)
            return 1'b1;
        if (op == regex_pkg::op_eot)
            return c == 8'h00;
        if ((op == regex_pkg::op_char && c == operand) || (op == regex_pkg::op_any && c != 8'h00))
        begin
            pc = pc + 1'b1;
            cc = cc + 1'b1;
        end
        else
            return 1'b0;
    end
    return 1'b0;
endfunction

`endif

/* sim/tb_regex_top.sv */
`default_nettype none

module tb_regex_top;

    localparam int clk_period        = 8;
    localparam int num_tests         = 6;
    localparam int match_cycles      = 200;
    localparam int access_cycles     = 4;
    localparam int rand_matches      = 24;
    localparam int accesses_per_test = 16 * rand_matches;
    localparam int watchdog_cycles   =
        num_tests * (match_cycles * rand_matches + access_cycles * accesses_per_test);
    localparam logic [10:0] text_base = 11'h400;

    logic        clk;
    logic        reset;
    logic [31:0] data_in_register;
    logic [31:0] address_register;
    logic [31:0] start_cc_pointer_register;
    logic [31:0] cmd_register;
    logic [31:0] status_register;
    logic [31:0] data_o_register;

    // what the DUT memory should hold
    logic [15:0] shadow [regex_pkg::mem_depth];
    int          errors;
    int          tests_passed;
    int          tests_failed;
    int          test_errors_start;

    `include "regex_model.svh"

    regex_top regex_top_inst (
        .clk                       (clk),
        .reset                     (reset),
        .data_in_register          (data_in_register),
        .address_register          (address_register),
        .start_cc_pointer_register (start_cc_pointer_register),
        .cmd_register              (cmd_register),
        .status_register           (status_register),
        .data_o_register           (data_o_register)
    );

    initial
    begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial
    begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, run did not complete", watchdog_cycles);
        $display("FAIL: see errors above");
        $finish;
    end

    // once running, status only moves on to a verdict
    running_holds: assert property (
        @(posedge clk) disable iff (reset)
        (status_register == regex_pkg::status_running && cmd_register != regex_pkg::cmd_reset)
        |=> (status_register == regex_pkg::status_running
            || status_register == regex_pkg::status_accepted
            || status_register == regex_pkg::status_rejected))
    else
    begin
        errors++;
        $display("[ERROR] status_register left running with %h", status_register);
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        assert (actual === expected)
        else
        begin
            errors++;
            $display("[ERROR] %s expected %h got %h", name, expected, actual);
        end
    endtask

    task automatic open_test();
        test_errors_start = errors;
    endtask

    task automatic close_test(input int num, input string name);
        if (errors == test_errors_start)
        begin
            tests_passed++;
            $display("test %0d %s: passed", num, name);
        end
        else
        begin
            tests_failed++;
            $display("test %0d %s: failed, %0d errors", num, name, errors - test_errors_start);
        end
    endtask

    task automatic write_pair(input logic [10:0] addr, input logic [31:0] data);
        @(posedge clk);
        address_register <= {21'd0, addr};
        data_in_register <= data;
        cmd_register     <= regex_pkg::cmd_write;
        @(posedge clk);
        cmd_register <= regex_pkg::cmd_nop;
        shadow[{addr[10:1], 1'b0}] = data[15:0];
        shadow[{addr[10:1], 1'b1}] = data[31:16];
    endtask

    // copy a shadow range into the DUT, whole pairs
    task automatic load_words(input int lo, input int hi);
        for (int a = lo & ~1; a <= hi; a += 2)
            write_pair(a, {shadow[a + 1], shadow[a]});
    endtask

    task automatic read_word(input logic [10:0] addr);
        @(posedge clk);
        address_register <= {21'd0, addr};
        cmd_register     <= regex_pkg::cmd_read;
        @(posedge clk);
        cmd_register <= regex_pkg::cmd_nop;
        @(negedge clk);
        compare_value("data_o_register", {16'd0, shadow[addr]}, data_o_register);
    endtask

    task automatic run_match(input logic [10:0] start, input bit expect_accept);
        int          cycles;
        logic [31:0] verdict;
        verdict = expect_accept ? regex_pkg::status_accepted : regex_pkg::status_rejected;
        @(posedge clk);
        start_cc_pointer_register <= {21'd0, start};
        cmd_register              <= regex_pkg::cmd_start;
        @(posedge clk);
        cmd_register <= regex_pkg::cmd_nop;
        @(negedge clk);
        compare_value("status_register", regex_pkg::status_running, status_register);
        cycles = 0;
        while (status_register == regex_pkg::status_running && cycles < match_cycles)
        begin
            @(negedge clk);
            cycles++;
        end
        if (status_register == regex_pkg::status_running)
        begin
            errors++;
            $display("match from %h did not finish within %0d cycles", start, match_cycles);
        end
        else
            compare_value("status_register", verdict, status_register);
    endtask

    task automatic soft_reset();
        @(posedge clk);
        cmd_register <= regex_pkg::cmd_reset;
        @(posedge clk);
        cmd_register <= regex_pkg::cmd_nop;
        @(negedge clk);
        compare_value("status_register", regex_pkg::status_idle, status_register);
    endtask

    // program abc then eot, text abc
    task automatic load_abc_case();
        shadow[0] = instr_word(regex_pkg::op_char, "a");
        shadow[1] = instr_word(regex_pkg::op_char, "b");
        shadow[2] = instr_word(regex_pkg::op_char, "c");
        shadow[3] = instr_word(regex_pkg::op_eot, 8'h00);
        shadow[text_base]     = char_word("a");
        shadow[text_base + 1] = char_word("b");
        shadow[text_base + 2] = char_word("c");
        shadow[text_base + 3] = char_word(8'h00);
        load_words(0, 3);
        load_words(text_base, text_base + 3);
    endtask

    task automatic build_random_case(output logic [10:0] start);
        int         text_len;
        int         prog_len;
        int         pick;
        logic [7:0] c;
        logic [7:0] op;
        text_len = $urandom % 7;
        for (int i = 0; i < text_len; i++)
            shadow[text_base + i] = char_word(8'h61 + $urandom % 3);
        shadow[text_base + text_len] = char_word(8'h00);
        start = text_base + $urandom % (text_len + 1);
        prog_len = 1 + $urandom % 6;
        for (int i = 0; i < prog_len; i++)
        begin
            // mostly follow the text so some matches succeed
            c = shadow[start + i][7:0];
            if (c == 8'h00 || $urandom % 4 == 0)
                c = 8'h61 + $urandom % 3;
            pick = $urandom % 10;
            if (i == prog_len - 1)
                op = (pick < 5) ? regex_pkg::op_eot : regex_pkg::op_accept;
            else if (pick < 6)
                op = regex_pkg::op_char;
            else if (pick < 8)
                op = regex_pkg::op_any;
            else
                op = (pick < 9) ? regex_pkg::op_eot : regex_pkg::op_accept;
            shadow[i] = instr_word(op, c);
        end
        load_words(0, prog_len - 1);
        load_words(text_base, text_base + text_len);
    endtask

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    initial
    begin
        logic [10:0] start;
        logic [10:0] addr;
        logic [31:0] data;
        void'($urandom(67));
        errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        reset = 1'b1;
        data_in_register = '0;
        address_register = '0;
        start_cc_pointer_register = '0;
        cmd_register = regex_pkg::cmd_nop;
        for (int i = 0; i < regex_pkg::mem_depth; i++)
            shadow[i] = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        open_test();
        @(negedge clk);
        compare_value("status_register", regex_pkg::status_idle, status_register);
        compare_value("data_o_register", 32'd0, data_o_register);
        close_test(1, "reset state");

        open_test();
        repeat (16)
        begin
            addr = $urandom;
            addr[0] = 1'b0;
            data = $urandom;
            write_pair(addr, data);
            read_word(addr);
            read_word(addr + 1'b1);
        end
        close_test(2, "write and read back");

        // verdict status holds until a reset, so each match is followed by one
        open_test();
        load_abc_case();
        run_match(text_base, 1'b1);
        soft_reset();
        shadow[text_base + 2] = char_word("d");
        load_words(text_base + 2, text_base + 3);
        run_match(text_base, 1'b0);
        soft_reset();
        close_test(3, "literal program");

        open_test();
        repeat (rand_matches)
        begin
            build_random_case(start);
            run_match(start, model_verdict(start));
            soft_reset();
        end
        close_test(4, "random programs");

        open_test();
        shadow[0] = instr_word(8'hee, 8'h00);
        load_words(0, 1);
        run_match(text_base, 1'b0);
        soft_reset();
        shadow[0] = instr_word(regex_pkg::op_any, 8'h00);
        shadow[1] = instr_word(regex_pkg::op_eot, 8'h00);
        shadow[text_base] = char_word(8'h00);
        load_words(0, 1);
        load_words(text_base, text_base + 1);
        run_match(text_base, 1'b0);
        soft_reset();
        close_test(5, "undefined opcode and any on terminator");

        open_test();
        load_abc_case();
        run_match(text_base, 1'b1);
        soft_reset();
        for (int i = 0; i < 4; i++)
        begin
            read_word(i);
            read_word(text_base + i);
        end
        run_match(text_base, 1'b1);
        close_test(6, "soft reset");

        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 num_tests, tests_passed, tests_failed, errors);
        if (errors == 0)
        begin
            $display("PASS: all tests");
        end
        else
        begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* design/regex_top.sv */
`default_nettype none

module regex_top (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [regex_pkg::reg_width-1:0] data_in_register,
    input  logic [regex_pkg::reg_width-1:0] address_register,
    input  logic [regex_pkg::reg_width-1:0] start_cc_pointer_register,
    input  logic [regex_pkg::reg_width-1:0] cmd_register,
    output logic [regex_pkg::reg_width-1:0] status_register,
    output logic [regex_pkg::reg_width-1:0] data_o_register
);

    logic                                 core_reset;
    regex_pkg::mem_wr_t                   wr;
    regex_pkg::mem_req_t                  rd;
    regex_pkg::mem_req_t                  cop_req;
    logic                                 mem_grant;
    logic                                 start_ready;
    logic [regex_pkg::mem_addr_width-1:0] cop_cc_pointer;
    logic                                 start_valid;
    logic                                 finish;
    logic                                 accept;
    logic [regex_pkg::mem_data_width-1:0] rd_data;

    // read data shared by host and coprocessor
    assign data_o_register =
        {{(regex_pkg::reg_width - regex_pkg::mem_data_width){1'b0}}, rd_data};

    ////////////////////////////////////////
    // instances
    ////////////////////////////////////////

    host_ctrl host_ctrl_inst (
        .clk            (clk),
        .reset          (reset),
        .cmd            (regex_pkg::cmd_e'(cmd_register)),
        .address        (address_register),
        .data_in        (data_in_register),
        .start_cc       (start_cc_pointer_register),
        .status         (status_register),
        .core_reset     (core_reset),
        .wr             (wr),
        .rd             (rd),
        .cop_req        (cop_req),
        .mem_grant      (mem_grant),
        .start_ready    (start_ready),
        .cop_cc_pointer (cop_cc_pointer),
        .start_valid    (start_valid),
        .finish         (finish),
        .accept         (accept)
    );

    parity_bram #(
        .depth (regex_pkg::mem_depth)
    ) parity_bram_inst (
        .clk     (clk),
        .reset   (core_reset),
        .wr      (wr),
        .rd      (rd),
        .rd_data (rd_data)
    );

    regex_coprocessor regex_coprocessor_inst (
        .clk              (clk),
        .reset            (core_reset),
        .mem_req          (cop_req),
        .mem_grant        (mem_grant),
        .mem_data         (rd_data),
        .start_ready      (start_ready),
        .start_cc_pointer (cop_cc_pointer),
        .start_valid      (start_valid),
        .finish           (finish),
        .accept           (accept)
    );

endmodule

`default_nettype wire

/* design/host_ctrl.sv */
`default_nettype none

module host_ctrl (
    input  logic                                 clk,
    input  logic                                 reset,
    input  regex_pkg::cmd_e                      cmd,
    input  logic [regex_pkg::reg_width-1:0]      address,
    input  logic [regex_pkg::reg_width-1:0]      data_in,
    input  logic [regex_pkg::reg_width-1:0]      start_cc,
    output regex_pkg::status_e                   status,
    output logic                                 core_reset,
    output regex_pkg::mem_wr_t                   wr,
    output regex_pkg::mem_req_t                  rd,
    input  regex_pkg::mem_req_t                  cop_req,
    output logic                                 mem_grant,
    output logic                                 start_ready,
    output logic [regex_pkg::mem_addr_width-1:0] cop_cc_pointer,
    input  logic                                 start_valid,
    input  logic                                 finish,
    input  logic                                 accept
);

    regex_pkg::status_e status_next;

    assign cop_cc_pointer = start_cc[regex_pkg::mem_addr_width-1:0];

    ////////////////////////////////////////
    // status register
    ////////////////////////////////////////

    // cmd_reset clears status from any state
    always_ff @(posedge clk)
    begin
        if (reset || cmd == regex_pkg::cmd_reset)
        begin
            status <= regex_pkg::status_idle;
        end
        else
        begin
            status <= status_next;
        end
    end

    ////////////////////////////////////////
    // command decode and memory port mux
    ////////////////////////////////////////

    always_comb
    begin
        status_next = status;
        core_reset  = reset;
        wr.en       = 1'b0;
        wr.addr     = address[regex_pkg::mem_addr_width-1:0];
        wr.data     = data_in;
        rd          = '0;
        mem_grant   = 1'b0;
        start_ready = 1'b0;

        case (status)
            regex_pkg::status_idle:
            begin
                // commands only decoded while idle
                case (cmd)
                    regex_pkg::cmd_write:
                    begin
                        wr.en = 1'b1;
                    end
                    regex_pkg::cmd_read:
                    begin
                        rd.valid = 1'b1;
                        rd.addr  = address[regex_pkg::mem_addr_width-1:0];
                    end
                    regex_pkg::cmd_reset:
                    begin
                        core_reset = 1'b1;
                    end
                    regex_pkg::cmd_start:
                    begin
                        start_ready = 1'b1;
                        mem_grant   = 1'b1;
                        rd          = cop_req;
                        if (start_valid)
                        begin
                            status_next = regex_pkg::status_running;
                        end
                    end
                    default: ;
                endcase
            end
            regex_pkg::status_running:
            begin
                // coprocessor owns the read port
                mem_grant = 1'b1;
                rd        = cop_req;
                if (finish)
                begin
                    if (accept)
                    begin
                        status_next = regex_pkg::status_accepted;
                    end
                    else
                    begin
                        status_next = regex_pkg::status_rejected;
                    end
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* design/regex_coprocessor.sv */
`default_nettype none

module regex_coprocessor (
    input  logic                                 clk,
    input  logic                                 reset,
    output regex_pkg::mem_req_t                  mem_req,
    input  logic                                 mem_grant,
    input  logic [regex_pkg::mem_data_width-1:0] mem_data,
    input  logic                                 start_ready,
    input  logic [regex_pkg::mem_addr_width-1:0] start_cc_pointer,
    output logic                                 start_valid,
    output logic                                 finish,
    output logic                                 accept
);

    typedef enum logic [2:0] {
        st_idle,
        st_fetch_instr,
        st_wait_instr,
        st_fetch_char,
        st_wait_char,
        st_done
    } state_e;

    state_e state;
    state_e state_next;

    logic [regex_pkg::mem_addr_width-1:0] pc;
    logic [regex_pkg::mem_addr_width-1:0] pc_next;
    logic [regex_pkg::mem_addr_width-1:0] cc;
    logic [regex_pkg::mem_addr_width-1:0] cc_next;
    logic                                 accept_q;
    logic                                 accept_next;

    logic [regex_pkg::mem_data_width-1:0] instr_q;
    regex_pkg::opcode_e                   new_op;
    regex_pkg::opcode_e                   held_op;
    logic [regex_pkg::char_width-1:0]     operand;
    logic [regex_pkg::char_width-1:0]     cur_char;

    // fresh instruction while waiting on it, latched copy afterwards
    assign new_op   = regex_pkg::opcode_e'(mem_data[15:8]);
    assign held_op  = regex_pkg::opcode_e'(instr_q[15:8]);
    assign operand  = instr_q[regex_pkg::char_width-1:0];
    assign cur_char = mem_data[regex_pkg::char_width-1:0];

    assign accept = accept_q;

    ////////////////////////////////////////
    // state registers
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state    <= st_idle;
            pc       <= '0;
            cc       <= '0;
            accept_q <= 1'b0;
        end
        else
        begin
            state    <= state_next;
            pc       <= pc_next;
            cc       <= cc_next;
            accept_q <= accept_next;
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == st_wait_instr)
        begin
            instr_q <= mem_data;
        end
    end

    ////////////////////////////////////////
    // next state and memory requests
    ////////////////////////////////////////

    always_comb
    begin
        state_next  = state;
        pc_next     = pc;
        cc_next     = cc;
        accept_next = accept_q;
        mem_req     = '0;
        start_valid = 1'b0;
        finish      = 1'b0;

        case (state)
            st_idle:
            begin
                if (start_ready)
                begin
                    start_valid = 1'b1;
                    pc_next     = '0;
                    cc_next     = start_cc_pointer;
                    accept_next = 1'b0;
                    state_next  = st_fetch_instr;
                end
            end
            st_fetch_instr:
            begin
                mem_req.valid = 1'b1;
                mem_req.addr  = pc;
                // hold the request under back-pressure
                if (mem_grant)
                begin
                    state_next = st_wait_instr;
                end
            end
            st_wait_instr:
            begin
                case (new_op)
                    regex_pkg::op_char,
                    regex_pkg::op_any,
                    regex_pkg::op_eot:
                    begin
                        state_next = st_fetch_char;
                    end
                    regex_pkg::op_accept:
                    begin
                        accept_next = 1'b1;
                        state_next  = st_done;
                    end
                    default:
                    begin
                        // undefined opcode
                        accept_next = 1'b0;
                        state_next  = st_done;
                    end
                endcase
            end
            st_fetch_char:
            begin
                mem_req.valid = 1'b1;
                mem_req.addr  = cc;
                if (mem_grant)
                begin
                    state_next = st_wait_char;
                end
            end
            st_wait_char:
            begin
                accept_next = 1'b0;
                state_next  = st_done;
                case (held_op)
                    regex_pkg::op_char:
                    begin
                        if (cur_char == operand)
                        begin
                            pc_next    = pc + 1'b1;
                            cc_next    = cc + 1'b1;
                            state_next = st_fetch_instr;
                        end
                    end
                    regex_pkg::op_any:
                    begin
                        // terminator does not count as a character
                        if (cur_char != '0)
                        begin
                            pc_next    = pc + 1'b1;
                            cc_next    = cc + 1'b1;
                            state_next = st_fetch_instr;
                        end
                    end
                    regex_pkg::op_eot:
                    begin
                        accept_next = (cur_char == '0);
                    end
                    default:
                    begin
                        accept_next = 1'b0;
                    end
                endcase
            end
            st_done:
            begin
                // one cycle pulse, verdict in accept_q
                finish     = 1'b1;
                state_next = st_idle;
            end
            default:
            begin
                state_next = st_idle;
            end
        endcase
    end

endmodule

`default_nettype wire

/* design/parity_bram.sv */
`default_nettype none

module parity_bram #(
    parameter int depth = regex_pkg::mem_depth
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  regex_pkg::mem_wr_t                   wr,
    input  regex_pkg::mem_req_t                  rd,
    output logic [regex_pkg::mem_data_width-1:0] rd_data
);

    localparam int index_width = $clog2(depth);

    logic [regex_pkg::mem_store_width-1:0] mem [depth];

    logic [index_width-1:0] wr_index_lo;
    logic [index_width-1:0] wr_index_hi;
    logic [index_width-1:0] rd_index;

    // stored layout per byte is {parity, byte}
    function automatic logic [regex_pkg::mem_store_width-1:0] add_parity(
        input logic [regex_pkg::mem_data_width-1:0] word
    );
        logic [7:0] lo_byte;
        logic [7:0] hi_byte;
        lo_byte = word[7:0];
        hi_byte = word[15:8];
        return {^hi_byte, hi_byte, ^lo_byte, lo_byte};
    endfunction

    function automatic logic [regex_pkg::mem_data_width-1:0] strip_parity(
        input logic [regex_pkg::mem_store_width-1:0] stored
    );
        return {stored[16:9], stored[7:0]};
    endfunction

    // address bit 0 ignored on writes
    assign wr_index_lo = {wr.addr[index_width-1:1], 1'b0};
    assign wr_index_hi = {wr.addr[index_width-1:1], 1'b1};
    assign rd_index    = rd.addr[index_width-1:0];

    ////////////////////////////////////////
    // write port, two words per write
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (wr.en)
        begin
            mem[wr_index_lo] <= add_parity(wr.data[15:0]);
            mem[wr_index_hi] <= add_parity(wr.data[31:16]);
        end
    end

    ////////////////////////////////////////
    // registered read port
    ////////////////////////////////////////

    // output holds when no read is requested
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rd_data <= '0;
        end
        else if (rd.valid)
        begin
            rd_data <= strip_parity(mem[rd_index]);
        end
    end

endmodule

`default_nettype wire

/* design/regex_pkg.sv */
`default_nettype none

package regex_pkg;

    ////////////////////////////////////////
    // widths
    ////////////////////////////////////////

    localparam int reg_width       = 32;
    localparam int mem_addr_width  = 11;
    localparam int mem_data_width  = 16;
    // two parity bits on top of the payload
    localparam int mem_store_width = 18;
    localparam int mem_depth       = 1 << mem_addr_width;
    localparam int char_width      = 8;

    ////////////////////////////////////////
    // register encodings
    ////////////////////////////////////////

    typedef enum logic [reg_width-1:0] {
        cmd_nop   = 32'd0,
        cmd_write = 32'd1,
        cmd_read  = 32'd2,
        cmd_reset = 32'd3,
        cmd_start = 32'd4
    } cmd_e;

    typedef enum logic [reg_width-1:0] {
        status_idle     = 32'd0,
        status_running  = 32'd1,
        status_accepted = 32'd2,
        status_rejected = 32'd3
    } status_e;

    // upper byte of an instruction word, operand in the lower byte
    typedef enum logic [7:0] {
        op_char   = 8'd1,
        op_any    = 8'd2,
        op_eot    = 8'd3,
        op_accept = 8'd4
    } opcode_e;

    ////////////////////////////////////////
    // memory port structs
    ////////////////////////////////////////

    typedef struct packed {
        logic                      valid;
        logic [mem_addr_width-1:0] addr;
    } mem_req_t;

    // data covers two words, low half at the even address
    typedef struct packed {
        logic                      en;
        logic [mem_addr_width-1:0] addr;
        logic [reg_width-1:0]      data;
    } mem_wr_t;

endpackage

`default_nettype wire
